/* logic/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath and register file geometry
`define CORE_XLEN       32
`define CORE_NREG       32
`define CORE_REG_IDX_W  5
`define CORE_OPC_W      6
`define CORE_IMM_W      12

// register form
`define CORE_OP_NOP     6'd0
`define CORE_OP_ADD     6'd1
`define CORE_OP_SUB     6'd2
`define CORE_OP_AND     6'd3
`define CORE_OP_OR      6'd4
`define CORE_OP_XOR     6'd5
`define CORE_OP_SLT     6'd6
// immediate form
`define CORE_OP_ADDI    6'd8
`define CORE_OP_ANDI    6'd9
`define CORE_OP_ORI     6'd10

`endif

/* logic/core_pkg.sv */
`include "core_settings.svh"

package core_pkg;

    typedef logic [`CORE_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`CORE_XLEN-1:0]      xlen_t;

    // values outside this list decode as no-op
    typedef enum logic [`CORE_OPC_W-1:0] {
        OP_NOP  = `CORE_OP_NOP,
        OP_ADD  = `CORE_OP_ADD,
        OP_SUB  = `CORE_OP_SUB,
        OP_AND  = `CORE_OP_AND,
        OP_OR   = `CORE_OP_OR,
        OP_XOR  = `CORE_OP_XOR,
        OP_SLT  = `CORE_OP_SLT,
        OP_ADDI = `CORE_OP_ADDI,
        OP_ANDI = `CORE_OP_ANDI,
        OP_ORI  = `CORE_OP_ORI
    } opcode_e;

    // one instruction word, two formats
    typedef union packed {
        struct packed {
            opcode_e                        opcode;
            logic [`CORE_REG_IDX_W-1:0]     rd;
            logic [`CORE_REG_IDX_W-1:0]     rj;
            logic [`CORE_REG_IDX_W-1:0]     rk;
            logic [10:0]                    zero;
        } reg_view;
        struct packed {
            opcode_e                        opcode;
            logic [`CORE_REG_IDX_W-1:0]     rd;
            logic [`CORE_REG_IDX_W-1:0]     rj;
            logic [`CORE_IMM_W-1:0]         imm12;
            logic [3:0]                     zero;
        } imm_view;
    } inst_u;

endpackage

/* logic/inst_decoder.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module inst_decoder (
    input  core_pkg::xlen_t    i_inst,
    output core_pkg::opcode_e  o_op,
    output core_pkg::reg_idx_t o_rd,
    output core_pkg::reg_idx_t o_rj,
    output core_pkg::reg_idx_t o_rk,
    output core_pkg::xlen_t    o_imm,
    output logic               o_uses_rk,
    output logic               o_writes
);
    import core_pkg::*;

    inst_u word;
    logic  known;

    assign word = i_inst;

    always_comb begin
        // rd and rj sit at the same bits in both views
        o_op      = word.reg_view.opcode;
        o_rd      = word.reg_view.rd;
        o_rj      = word.reg_view.rj;
        o_rk      = '0;
        o_imm     = '0;
        o_uses_rk = 1'b0;
        known     = 1'b1;
        case (word.reg_view.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
                o_rk      = word.reg_view.rk;
                o_uses_rk = 1'b1;
            end
            OP_ADDI: begin
                o_imm = {{(`CORE_XLEN-`CORE_IMM_W){word.imm_view.imm12[`CORE_IMM_W-1]}},
                         word.imm_view.imm12};
            end
            OP_ANDI, OP_ORI: begin
                // logical immediates are zero-extended
                o_imm = {{(`CORE_XLEN-`CORE_IMM_W){1'b0}}, word.imm_view.imm12};
            end
            default: begin
                known = 1'b0;
            end
        endcase
        // r0 is hardwired, so writing it is dropped here
        o_writes = known && (o_rd != '0);
    end

endmodule

/* logic/issue_stage.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module issue_stage (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      i_wb_cyc,
    input  logic                      i_wb_stb,
    input  logic                      i_wb_we,
    input  logic [2*`CORE_XLEN-1:0]   i_wb_dat,
    output logic                      o_wb_ack,
    output logic                      o_iss0_valid,
    output core_pkg::opcode_e         o_iss0_op,
    output core_pkg::reg_idx_t        o_iss0_rd,
    output core_pkg::reg_idx_t        o_iss0_rj,
    output core_pkg::reg_idx_t        o_iss0_rk,
    output core_pkg::xlen_t           o_iss0_imm,
    output logic                      o_iss1_valid,
    output core_pkg::opcode_e         o_iss1_op,
    output core_pkg::reg_idx_t        o_iss1_rd,
    output core_pkg::reg_idx_t        o_iss1_rj,
    output core_pkg::reg_idx_t        o_iss1_rk,
    output core_pkg::xlen_t           o_iss1_imm
);
    import core_pkg::*;

    opcode_e  dec0_op, dec1_op;
    reg_idx_t dec0_rd, dec0_rj, dec0_rk;
    reg_idx_t dec1_rd, dec1_rj, dec1_rk;
    xlen_t    dec0_imm, dec1_imm;
    logic     dec1_uses_rk;
    logic     dec0_writes, dec1_writes;
    logic     accept, issue_now, dep, hold;

    inst_decoder u_dec0 (
        .i_inst(i_wb_dat[`CORE_XLEN-1:0]),
        .o_op(dec0_op), .o_rd(dec0_rd), .o_rj(dec0_rj), .o_rk(dec0_rk),
        .o_imm(dec0_imm), .o_uses_rk(), .o_writes(dec0_writes)
    );

    inst_decoder u_dec1 (
        .i_inst(i_wb_dat[2*`CORE_XLEN-1:`CORE_XLEN]),
        .o_op(dec1_op), .o_rd(dec1_rd), .o_rj(dec1_rj), .o_rk(dec1_rk),
        .o_imm(dec1_imm), .o_uses_rk(dec1_uses_rk), .o_writes(dec1_writes)
    );

    // nothing new is taken during the ack cycle or while lane 1 waits
    assign accept    = i_wb_cyc && i_wb_stb && !o_wb_ack && !hold;
    assign issue_now = accept && i_wb_we;

    // lane 1 reads what lane 0 is about to write
    assign dep = dec0_writes &&
                 ((dec1_rj == dec0_rd) || (dec1_uses_rk && (dec1_rk == dec0_rd)));

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_wb_ack     <= 1'b0;
            hold         <= 1'b0;
            o_iss0_valid <= 1'b0;
            o_iss1_valid <= 1'b0;
        end else begin
            o_iss0_valid <= issue_now && dec0_writes;
            o_iss1_valid <= dec1_writes && (hold || (issue_now && !dep));
            hold         <= issue_now && dep;
            o_wb_ack     <= hold || (accept && !(i_wb_we && dep));
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            o_iss0_op  <= dec0_op;
            o_iss0_rd  <= dec0_rd;
            o_iss0_rj  <= dec0_rj;
            o_iss0_rk  <= dec0_rk;
            o_iss0_imm <= dec0_imm;
        end
        // held lane 1 comes from the bus word, which stays put until ack
        if (accept || hold) begin
            o_iss1_op  <= dec1_op;
            o_iss1_rd  <= dec1_rd;
            o_iss1_rj  <= dec1_rj;
            o_iss1_rk  <= dec1_rk;
            o_iss1_imm <= dec1_imm;
        end
    end

    a_ack_in_cycle: assert property (@(posedge aclk) disable iff (!aresetn)
        o_wb_ack |-> (i_wb_cyc && i_wb_stb));

    a_ack_single: assert property (@(posedge aclk) disable iff (!aresetn)
        o_wb_ack |=> !o_wb_ack);

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module register_file (
    input  logic               aclk,
    input  logic               aresetn,
    input  core_pkg::reg_idx_t i_rd_idx0j,
    input  core_pkg::reg_idx_t i_rd_idx0k,
    input  core_pkg::reg_idx_t i_rd_idx1j,
    input  core_pkg::reg_idx_t i_rd_idx1k,
    input  logic               i_wr_en0,
    input  logic               i_wr_en1,
    input  core_pkg::reg_idx_t i_wr_idx0,
    input  core_pkg::reg_idx_t i_wr_idx1,
    input  core_pkg::xlen_t    i_wr_data0,
    input  core_pkg::xlen_t    i_wr_data1,
    output core_pkg::xlen_t    o_rd_data0j,
    output core_pkg::xlen_t    o_rd_data0k,
    output core_pkg::xlen_t    o_rd_data1j,
    output core_pkg::xlen_t    o_rd_data1k
);
    import core_pkg::*;

    xlen_t    regs [`CORE_NREG];
    reg_idx_t rd_idx [4];
    xlen_t    rd_data [4];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            regs <= '{default: '0};
        end else begin
            if (i_wr_en0 && (i_wr_idx0 != '0))
                regs[i_wr_idx0] <= i_wr_data0;
            // lane 1 is younger, its write lands last
            if (i_wr_en1 && (i_wr_idx1 != '0))
                regs[i_wr_idx1] <= i_wr_data1;
        end
    end

    assign rd_idx[0] = i_rd_idx0j;
    assign rd_idx[1] = i_rd_idx0k;
    assign rd_idx[2] = i_rd_idx1j;
    assign rd_idx[3] = i_rd_idx1k;

    // write-first bypass, lane 1 ahead of lane 0
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (rd_idx[p] == '0)
                rd_data[p] = '0;
            else if (i_wr_en1 && (i_wr_idx1 == rd_idx[p]))
                rd_data[p] = i_wr_data1;
            else if (i_wr_en0 && (i_wr_idx0 == rd_idx[p]))
                rd_data[p] = i_wr_data0;
            else
                rd_data[p] = regs[rd_idx[p]];
        end
    end

    assign o_rd_data0j = rd_data[0];
    assign o_rd_data0k = rd_data[1];
    assign o_rd_data1j = rd_data[2];
    assign o_rd_data1k = rd_data[3];

    a_no_r0_write: assert property (@(posedge aclk) disable iff (!aresetn)
        !(i_wr_en0 && (i_wr_idx0 == '0)) && !(i_wr_en1 && (i_wr_idx1 == '0)));

endmodule

/* logic/exec_lane.sv */
`timescale 1ns/1ps

module exec_lane (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               i_valid,
    input  core_pkg::opcode_e  i_op,
    input  core_pkg::reg_idx_t i_rd,
    input  core_pkg::xlen_t    i_imm,
    input  core_pkg::xlen_t    i_src_j,
    input  core_pkg::xlen_t    i_src_k,
    output logic               o_wb_en,
    output core_pkg::reg_idx_t o_wb_rd,
    output core_pkg::xlen_t    o_wb_data
);
    import core_pkg::*;

    xlen_t operand_b;
    xlen_t result;
    logic  writes;

    always_comb begin
        operand_b = (i_op inside {OP_ADDI, OP_ANDI, OP_ORI}) ? i_imm : i_src_k;
        result    = '0;
        writes    = 1'b1;
        case (i_op)
            OP_ADD, OP_ADDI: result = i_src_j + operand_b;
            OP_SUB:          result = i_src_j - operand_b;
            OP_AND, OP_ANDI: result = i_src_j & operand_b;
            OP_OR, OP_ORI:   result = i_src_j | operand_b;
            OP_XOR:          result = i_src_j ^ operand_b;
            OP_SLT:          result = xlen_t'($signed(i_src_j) < $signed(operand_b));
            // nop and unknown encodings
            default:         writes = 1'b0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn)
            o_wb_en <= 1'b0;
        else
            o_wb_en <= i_valid && writes;
    end

    always_ff @(posedge aclk) begin
        if (i_valid) begin
            o_wb_rd   <= i_rd;
            o_wb_data <= result;
        end
    end

    // rd of zero must already be filtered at issue
    a_no_r0_wb: assert property (@(posedge aclk) disable iff (!aresetn)
        o_wb_en |-> (o_wb_rd != '0));

endmodule

/* logic/core_top.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_top (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      i_wb_cyc,
    input  logic                      i_wb_stb,
    input  logic                      i_wb_we,
    input  logic [2*`CORE_XLEN-1:0]   i_wb_dat,
    output logic                      o_wb_ack,
    output logic                      o_wb0_en,
    output core_pkg::reg_idx_t        o_wb0_rd,
    output core_pkg::xlen_t           o_wb0_data,
    output logic                      o_wb1_en,
    output core_pkg::reg_idx_t        o_wb1_rd,
    output core_pkg::xlen_t           o_wb1_data
);
    import core_pkg::*;

    logic     iss0_valid, iss1_valid;
    opcode_e  iss0_op, iss1_op;
    reg_idx_t iss0_rd, iss0_rj, iss0_rk;
    reg_idx_t iss1_rd, iss1_rj, iss1_rk;
    xlen_t    iss0_imm, iss1_imm;
    xlen_t    rf_data0j, rf_data0k, rf_data1j, rf_data1k;

    issue_stage u_issue_stage (
        .aclk(aclk), .aresetn(aresetn),
        .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
        .i_wb_dat(i_wb_dat), .o_wb_ack(o_wb_ack),
        .o_iss0_valid(iss0_valid), .o_iss0_op(iss0_op), .o_iss0_rd(iss0_rd),
        .o_iss0_rj(iss0_rj), .o_iss0_rk(iss0_rk), .o_iss0_imm(iss0_imm),
        .o_iss1_valid(iss1_valid), .o_iss1_op(iss1_op), .o_iss1_rd(iss1_rd),
        .o_iss1_rj(iss1_rj), .o_iss1_rk(iss1_rk), .o_iss1_imm(iss1_imm)
    );

    // write ports take the lane results straight from the writeback outputs
    register_file u_register_file (
        .aclk(aclk), .aresetn(aresetn),
        .i_rd_idx0j(iss0_rj), .i_rd_idx0k(iss0_rk),
        .i_rd_idx1j(iss1_rj), .i_rd_idx1k(iss1_rk),
        .i_wr_en0(o_wb0_en), .i_wr_en1(o_wb1_en),
        .i_wr_idx0(o_wb0_rd), .i_wr_idx1(o_wb1_rd),
        .i_wr_data0(o_wb0_data), .i_wr_data1(o_wb1_data),
        .o_rd_data0j(rf_data0j), .o_rd_data0k(rf_data0k),
        .o_rd_data1j(rf_data1j), .o_rd_data1k(rf_data1k)
    );

    exec_lane u_exec_lane0 (
        .aclk(aclk), .aresetn(aresetn),
        .i_valid(iss0_valid), .i_op(iss0_op), .i_rd(iss0_rd), .i_imm(iss0_imm),
        .i_src_j(rf_data0j), .i_src_k(rf_data0k),
        .o_wb_en(o_wb0_en), .o_wb_rd(o_wb0_rd), .o_wb_data(o_wb0_data)
    );

    exec_lane u_exec_lane1 (
        .aclk(aclk), .aresetn(aresetn),
        .i_valid(iss1_valid), .i_op(iss1_op), .i_rd(iss1_rd), .i_imm(iss1_imm),
        .i_src_j(rf_data1j), .i_src_k(rf_data1k),
        .o_wb_en(o_wb1_en), .o_wb_rd(o_wb1_rd), .o_wb_data(o_wb1_data)
    );

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic aclk,
    output logic aresetn
);
    // 40 ns period
    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    initial begin
        aresetn = 1'b0;
        repeat (8) @(posedge aclk);
        aresetn <= 1'b1;
    end

endmodule

/* sim/core_top_tb.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_top_tb;
    import core_pkg::*;

    // directed, random and readback bundles of 10 cycles each at most
    localparam int BUNDLES  = 14 + 200 + 16;
    localparam int LIMIT_NS = (BUNDLES * 10 + 8) * 40;

    typedef struct packed {
        logic        lane;
        reg_idx_t    rd;
        xlen_t       data;
        int unsigned cyc;
    } wb_event_t;

    logic                    aclk, aresetn;
    logic                    i_wb_cyc, i_wb_stb, i_wb_we;
    logic [2*`CORE_XLEN-1:0] i_wb_dat;
    logic                    o_wb_ack, o_wb0_en, o_wb1_en;
    reg_idx_t                o_wb0_rd, o_wb1_rd;
    xlen_t                   o_wb0_data, o_wb1_data;

    xlen_t       model [`CORE_NREG];
    wb_event_t   seen [$];
    wb_event_t   expected [$];
    int unsigned cycle_no = 0;
    int unsigned ack_cycle = 0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr = 32'hab4d_ab09;
    string       test_name = "none";

    tb_clock_gen u_clock_gen (.aclk(aclk), .aresetn(aresetn));

    core_top u_core_top (
        .aclk(aclk), .aresetn(aresetn), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
        .i_wb_we(i_wb_we), .i_wb_dat(i_wb_dat), .o_wb_ack(o_wb_ack),
        .o_wb0_en(o_wb0_en), .o_wb0_rd(o_wb0_rd), .o_wb0_data(o_wb0_data),
        .o_wb1_en(o_wb1_en), .o_wb1_rd(o_wb1_rd), .o_wb1_data(o_wb1_data)
    );

    always @(posedge aclk) cycle_no <= cycle_no + 1;

    // lane 0 is logged first within a cycle
    always @(negedge aclk) begin
        if (o_wb0_en === 1'b1)
            seen.push_back('{1'b0, o_wb0_rd, o_wb0_data, cycle_no});
        if (o_wb1_en === 1'b1)
            seen.push_back('{1'b1, o_wb1_rd, o_wb1_data, cycle_no});
    end

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired after %0d ns, the DUT stopped responding", LIMIT_NS);
        $display("Test failed");
        $finish;
    end

    task automatic check_data(input xlen_t exp_v, input xlen_t act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("Error in %s: data expected %h, actual %h", test_name, exp_v, act_v);
        end
    endtask

    task automatic check_idx(input reg_idx_t exp_v, input reg_idx_t act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("Error in %s: rd expected %0d, actual %0d", test_name, exp_v, act_v);
        end
    endtask

    task automatic check_bit(input logic exp_v, input logic act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("Error in %s: bit expected %b, actual %b", test_name, exp_v, act_v);
        end
    endtask

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic xlen_t encode(input logic [5:0] op, input reg_idx_t rd, rj, rk,
                                     input logic [11:0] imm);
        if (op inside {OP_ADDI, OP_ANDI, OP_ORI})
            return {op, rd, rj, imm, 4'b0};
        return {op, rd, rj, rk, 11'b0};
    endfunction

    function automatic logic writes_reg(input xlen_t w);
        return (w[31:26] inside {[OP_ADD:OP_SLT], OP_ADDI, OP_ANDI, OP_ORI}) &&
               (w[25:21] != '0);
    endfunction

    // off is the expected cycle relative to ack
    task automatic model_inst(input xlen_t w, input logic lane, input int unsigned off);
        xlen_t a, b, zimm, simm, r;
        a    = model[w[20:16]];
        b    = model[w[15:11]];
        zimm = {20'b0, w[15:4]};
        simm = {{20{w[15]}}, w[15:4]};
        case (w[31:26])
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI: r = a + simm;
            OP_ANDI: r = a & zimm;
            OP_ORI:  r = a | zimm;
            default: r = '0;
        endcase
        if (writes_reg(w)) begin
            model[w[25:21]] = r;
            expected.push_back('{lane, w[25:21], r, off});
        end
    endtask

    task automatic send_bundle(input xlen_t w0, input xlen_t w1, input logic we);
        int waited;
        waited = 0;
        @(posedge aclk);
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        i_wb_we  <= we;
        i_wb_dat <= {w1, w0};
        do begin
            @(negedge aclk);
            waited++;
        end while (o_wb_ack !== 1'b1 && waited < 20);
        ack_cycle = cycle_no;
        if (o_wb_ack !== 1'b1) begin
            errors++;
            $display("%s: bundle was never acknowledged", test_name);
        end
        @(posedge aclk);
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
    endtask

    task automatic collect_wb();
        wb_event_t got, want;
        // by this edge the monitor has logged the cycle after ack
        @(posedge aclk);
        if (seen.size() != expected.size()) begin
            errors++;
            $display("%s: %0d writebacks expected but %0d seen", test_name,
                     expected.size(), seen.size());
        end
        while (seen.size() > 0 && expected.size() > 0) begin
            got  = seen.pop_front();
            want = expected.pop_front();
            check_bit(want.lane, got.lane);
            check_idx(want.rd, got.rd);
            check_data(want.data, got.data);
            if (got.cyc != ack_cycle + want.cyc) begin
                errors++;
                $display("%s: writeback to r%0d came in the wrong cycle", test_name, got.rd);
            end
        end
        seen.delete();
        expected.delete();
    endtask

    task automatic issue_pair(input xlen_t w0, input xlen_t w1);
        logic dep;
        // lane 1 is held when it reads lane 0's destination
        dep = writes_reg(w0) && ((w1[20:16] == w0[25:21]) ||
              ((w1[31:26] inside {[OP_ADD:OP_SLT]}) && (w1[15:11] == w0[25:21])));
        model_inst(w0, 1'b0, dep ? 0 : 1);
        model_inst(w1, 1'b1, 1);
        send_bundle(w0, w1, 1'b1);
        collect_wb();
    endtask

    task automatic test_reset();
        test_name = "reset";
        repeat (4) begin
            @(negedge aclk);
            check_bit(1'b0, o_wb_ack);
            check_bit(1'b0, o_wb0_en);
            check_bit(1'b0, o_wb1_en);
        end
        // strobe without we is acked and issues nothing
        send_bundle(encode(OP_ADDI, 5'd1, 5'd0, '0, 12'h011), '0, 1'b0);
        collect_wb();
    endtask

    task automatic test_reg_ops();
        test_name = "reg_ops";
        issue_pair(encode(OP_ADDI, 5'd1, 5'd0, '0, 12'hffb),
                   encode(OP_ORI, 5'd2, 5'd0, '0, 12'h7a5));
        issue_pair(encode(OP_ADD, 5'd3, 5'd1, 5'd2, '0), encode(OP_SUB, 5'd4, 5'd1, 5'd2, '0));
        issue_pair(encode(OP_AND, 5'd5, 5'd1, 5'd2, '0), encode(OP_OR, 5'd6, 5'd1, 5'd2, '0));
        issue_pair(encode(OP_XOR, 5'd7, 5'd1, 5'd2, '0), encode(OP_SLT, 5'd8, 5'd1, 5'd2, '0));
        issue_pair(encode(OP_SLT, 5'd9, 5'd2, 5'd1, '0), '0);
    endtask

    task automatic test_imm();
        test_name = "imm_forms";
        issue_pair(encode(OP_ADDI, 5'd10, 5'd2, '0, 12'h800),
                   encode(OP_ANDI, 5'd11, 5'd1, '0, 12'h90f));
        issue_pair(encode(OP_ORI, 5'd12, 5'd0, '0, 12'h9ab),
                   encode(OP_ADDI, 5'd13, 5'd0, '0, 12'hfff));
    endtask

    task automatic test_dep();
        test_name = "dependent";
        issue_pair(encode(OP_ADDI, 5'd14, 5'd1, '0, 12'h007),
                   encode(OP_ADD, 5'd15, 5'd14, 5'd2, '0));
        issue_pair(encode(OP_ADDI, 5'd16, 5'd0, '0, 12'h003),
                   encode(OP_SUB, 5'd17, 5'd2, 5'd16, '0));
        // imm bits alias rk = r18 yet the pair stays independent
        issue_pair(encode(OP_ADDI, 5'd18, 5'd0, '0, 12'h001),
                   encode(OP_ADDI, 5'd19, 5'd2, '0, 12'h900));
    endtask

    task automatic test_nowrite();
        test_name = "no_write";
        issue_pair(encode(OP_ADDI, 5'd0, 5'd1, '0, 12'h005), '0);
        issue_pair(encode(6'd7, 5'd20, 5'd1, 5'd2, '0), encode(OP_ADD, 5'd0, 5'd1, 5'd2, '0));
        issue_pair(encode(OP_ADDI, 5'd21, 5'd0, '0, '0), encode(OP_OR, 5'd22, 5'd0, 5'd0, '0));
    endtask

    task automatic test_random();
        logic [5:0]  ops [16];
        logic [31:0] bits;
        xlen_t       w [2];
        ops = '{OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_ADDI,
                OP_ANDI, OP_ORI, OP_ADD, OP_ADDI, 6'd7, 6'd11, 6'd33, 6'd63};
        test_name = "random";
        repeat (200) begin
            for (int n = 0; n < 2; n++) begin
                bits = rand_bits(31);
                w[n] = encode(ops[bits[30:27]], bits[26:22], bits[21:17], bits[16:12],
                              bits[11:0]);
            end
            issue_pair(w[0], w[1]);
        end
        test_name = "readback";
        for (int r = 1; r < 32; r += 2)
            issue_pair(encode(OP_ADDI, reg_idx_t'(r), reg_idx_t'(r), '0, '0),
                       (r < 31) ? encode(OP_ADDI, reg_idx_t'(r + 1), reg_idx_t'(r + 1), '0, '0)
                                : '0);
    endtask

    initial begin
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        i_wb_dat = '0;
        model    = '{default: '0};
        @(posedge aresetn);
        test_reset();
        test_reg_ops();
        test_imm();
        test_dep();
        test_nowrite();
        test_random();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+logic
logic/core_pkg.sv
logic/inst_decoder.sv
logic/issue_stage.sv
logic/register_file.sv
logic/exec_lane.sv
logic/core_top.sv
sim/tb_clock_gen.sv
sim/core_top_tb.sv
